// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= rvDecodeTb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0

SOURCES := $(wildcard hw/*.sv tb/*.sv tb/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
+incdir+tb
hw/rvDecodePkg.sv
hw/instrClassify.sv
hw/aluCtrlDecode.sv
hw/memCtrlDecode.sv
hw/branchCtrlDecode.sv
hw/sysCtrlDecode.sv
hw/rvDecodeTop.sv
tb/rvDecodeTb.sv

// ==== hw/aluCtrlDecode.sv ====
`timescale 1ns/1ps

module aluCtrlDecode (
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  input  rvDecodePkg::instrClassT      cls_i,
  output logic                         aluSrcA_o,
  output logic [1:0]                   aluSrcB_o,
  output rvDecodePkg::aluOpT           aluOp_o,
  output rvDecodePkg::mulOpT           mulOp_o
);
  import rvDecodePkg::*;

  funct3T funct3;
  funct7T funct7;
  logic   alt;      // arithmetic shift
  logic   subSel;   // sub/subw, register forms only
  logic   isMulDiv;
  aluOpT  intOp;    // op / op-imm table
  aluOpT  wordOp;   // op-32 / op-imm-32 table
  aluOpT  mdOp;     // mul/div/rem
  mulOpT  mdMul;
  aluOpT  mdwOp;    // mulw/divw/remw

  assign funct3   = instr_i[funct3Hi:funct3Lo];
  assign funct7   = instr_i[funct7Hi:funct7Lo];
  assign alt      = instr_i[altBit];
  assign subSel   = (funct7 == funct7Alt) && ((cls_i == clsOp) || (cls_i == clsOp32));
  assign isMulDiv = (funct7 == funct7MulDiv);

  always_comb begin
    case (funct3)
      3'b000:  intOp = subSel ? aluSub : aluAdd;
      3'b001:  intOp = aluSll;
      3'b010:  intOp = aluSlt;
      3'b011:  intOp = aluSltu;
      3'b100:  intOp = aluXor;
      3'b101:  intOp = alt ? aluSra : aluSrl;
      3'b110:  intOp = aluOr;
      default: intOp = aluAnd;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  wordOp = subSel ? aluSubw : aluAddw;
      3'b001:  wordOp = aluSllw;
      default: wordOp = alt ? aluSraw : aluSrlw; // 101 rule
    endcase
  end

  always_comb begin
    mdOp  = aluMul;
    mdMul = mulLow;
    case (funct3)
      3'b001:  mdMul = mulH;
      3'b010:  mdMul = mulHsu;
      3'b011:  mdMul = mulHu;
      3'b100:  mdOp  = aluDiv;
      3'b101:  mdOp  = aluDivu;
      3'b110:  mdOp  = aluRem;
      3'b111:  mdOp  = aluRemu;
      default: mdOp  = aluMul; // plain mul
    endcase
  end

  always_comb begin
    case (funct3)
      3'b100:  mdwOp = aluDivw;
      3'b101:  mdwOp = aluDivuw;
      3'b110:  mdwOp = aluRemw;
      3'b111:  mdwOp = aluRemuw;
      default: mdwOp = aluMulw;
    endcase
  end

  always_comb begin
    aluSrcA_o = srcARs1;
    aluSrcB_o = srcBRs2;
    aluOp_o   = aluAdd;
    mulOp_o   = mulLow;
    case (cls_i)
      clsLui: begin
        aluSrcB_o = srcBImm;
        aluOp_o   = aluPassB;
      end
      clsAuipc: begin
        aluSrcA_o = srcAPc;
        aluSrcB_o = srcBImm;
      end
      clsJal, clsJalr: begin
        aluSrcA_o = srcAPc; // link value pc+4
        aluSrcB_o = srcBFour;
      end
      clsBranch:                   aluOp_o   = funct3[1] ? aluSltu : aluSlt;
      clsLoad, clsStore, clsSystem: aluSrcB_o = srcBImm; // address / csr operand
      clsOpImm: begin
        aluSrcB_o = srcBImm;
        aluOp_o   = intOp;
      end
      clsOpImm32: begin
        aluSrcB_o = srcBImm;
        aluOp_o   = wordOp;
      end
      clsOp: begin
        aluOp_o = isMulDiv ? mdOp : intOp;
        mulOp_o = isMulDiv ? mdMul : mulLow;
      end
      clsOp32:                     aluOp_o   = isMulDiv ? mdwOp : wordOp;
      default:                     aluOp_o   = aluAdd; // fence.i, illegal
    endcase
  end

endmodule

// ==== hw/branchCtrlDecode.sv ====
`timescale 1ns/1ps

module branchCtrlDecode (
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  input  rvDecodePkg::instrClassT      cls_i,
  output rvDecodePkg::branchT          branch_o
);
  import rvDecodePkg::*;

  funct3T funct3;
  branchT condKind; // conditional branch kind

  assign funct3 = instr_i[funct3Hi:funct3Lo];

  // signed and unsigned compares share a kind
  always_comb begin
    case (funct3)
      3'b000:         condKind = brEq;
      3'b001:         condKind = brNe;
      3'b100, 3'b110: condKind = brLt;
      3'b101, 3'b111: condKind = brGe;
      default:        condKind = brNone; // reserved funct3
    endcase
  end

  always_comb begin
    case (cls_i)
      clsJal:    branch_o = brJal;
      clsJalr:   branch_o = brJalr;
      clsBranch: branch_o = condKind;
      default:   branch_o = brNone;
    endcase
  end

endmodule

// ==== hw/instrClassify.sv ====
`timescale 1ns/1ps

module instrClassify (
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  output rvDecodePkg::instrClassT      cls_o,
  output rvDecodePkg::immTypeT         immType_o,
  output logic                         regWen_o,
  output logic                         illegal_o
);
  import rvDecodePkg::*;

  opcodeT opcode;
  funct3T funct3;
  sysFnT  sysFn;
  logic   sysFnOk; // one of the three traps
  logic   sysTrap; // funct3 000, no rd write

  assign opcode  = instr_i[opcodeHi:opcodeLo];
  assign funct3  = instr_i[funct3Hi:funct3Lo];
  assign sysFn   = instr_i[sysFnHi:sysFnLo];
  assign sysFnOk = (sysFn == sysEcall) || (sysFn == sysEbreak) || (sysFn == sysMret);
  assign sysTrap = (funct3 == 3'b000);

  // opcode to class, bad funct3 combos fall to illegal
  always_comb begin
    cls_o = clsIllegal;
    case (opcode)
      opcLui:     cls_o = clsLui;
      opcAuipc:   cls_o = clsAuipc;
      opcJal:     cls_o = clsJal;
      opcJalr:    cls_o = clsJalr;
      opcBranch: begin
        if (funct3[2:1] != 2'b01) cls_o = clsBranch; // 010/011 reserved
      end
      opcLoad: begin
        if (funct3 != 3'b111) cls_o = clsLoad;
      end
      opcStore: begin
        if (!funct3[2]) cls_o = clsStore; // sb..sd only
      end
      opcOpImm:   cls_o = clsOpImm;
      opcOp:      cls_o = clsOp;
      opcOpImm32: cls_o = clsOpImm32;
      opcOp32:    cls_o = clsOp32;
      opcSystem: begin
        if (funct3 == 3'b100) begin
          cls_o = clsIllegal;
        end else if (sysTrap && !sysFnOk) begin
          cls_o = clsIllegal; // unknown trap function
        end else begin
          cls_o = clsSystem;
        end
      end
      opcFenceI:  cls_o = clsFenceI;
      default:    cls_o = clsIllegal;
    endcase
  end

  // immediate format and rd write follow the class
  always_comb begin
    immType_o = immI;
    regWen_o  = 1'b1;
    case (cls_o)
      clsLui, clsAuipc: immType_o = immU;
      clsJal:           immType_o = immJ;
      clsBranch: begin
        immType_o = immB;
        regWen_o  = 1'b0;
      end
      clsStore: begin
        immType_o = immS;
        regWen_o  = 1'b0;
      end
      clsOp, clsOp32:   immType_o = immR;
      clsSystem:        regWen_o  = !sysTrap; // csr ops write rd
      clsFenceI:        regWen_o  = 1'b0;
      clsIllegal:       regWen_o  = 1'b0;
      default:          regWen_o  = 1'b1; // jalr, loads, op-imm
    endcase
  end

  assign illegal_o = (cls_o == clsIllegal);

endmodule

// ==== hw/memCtrlDecode.sv ====
`timescale 1ns/1ps

module memCtrlDecode (
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  input  rvDecodePkg::instrClassT      cls_i,
  output rvDecodePkg::memOpT           memOp_o,
  output logic                         memWen_o,
  output logic                         memToReg_o
);
  import rvDecodePkg::*;

  funct3T funct3;
  memOpT  accKind; // size and sign from funct3
  logic   isMem;

  assign funct3 = instr_i[funct3Hi:funct3Lo];
  assign isMem  = (cls_i == clsLoad) || (cls_i == clsStore);

  always_comb begin
    case (funct3)
      3'b000:  accKind = memByte;
      3'b001:  accKind = memHalf;
      3'b010:  accKind = memWord;
      3'b011:  accKind = memDouble;
      3'b100:  accKind = memByteU;
      3'b101:  accKind = memHalfU;
      3'b110:  accKind = memWordU;
      default: accKind = memWord; // 111 never legal
    endcase
  end

  assign memOp_o    = isMem ? accKind : memWord;
  assign memWen_o   = (cls_i == clsStore);
  assign memToReg_o = (cls_i == clsLoad); // rd from load data

endmodule

// ==== hw/rvDecodePkg.sv ====
package rvDecodePkg;

  localparam int ilen = 32; // instruction width

  // field positions inside the instruction word
  localparam int opcodeLo = 0;
  localparam int opcodeHi = 6;
  localparam int funct3Lo = 12;
  localparam int funct3Hi = 14;
  localparam int funct7Lo = 25;
  localparam int funct7Hi = 31;
  localparam int altBit   = 30; // sra vs srl
  localparam int sysFnLo  = 20; // ecall/ebreak/mret function
  localparam int sysFnHi  = 31;

  typedef logic [opcodeHi-opcodeLo:0] opcodeT;
  typedef logic [funct3Hi-funct3Lo:0] funct3T;
  typedef logic [funct7Hi-funct7Lo:0] funct7T;
  typedef logic [sysFnHi-sysFnLo:0]   sysFnT;

  localparam opcodeT opcLui     = 7'b0110111;
  localparam opcodeT opcAuipc   = 7'b0010111;
  localparam opcodeT opcJal     = 7'b1101111;
  localparam opcodeT opcJalr    = 7'b1100111;
  localparam opcodeT opcBranch  = 7'b1100011;
  localparam opcodeT opcLoad    = 7'b0000011;
  localparam opcodeT opcStore   = 7'b0100011;
  localparam opcodeT opcOpImm   = 7'b0010011;
  localparam opcodeT opcOp      = 7'b0110011;
  localparam opcodeT opcOpImm32 = 7'b0011011;
  localparam opcodeT opcOp32    = 7'b0111011;
  localparam opcodeT opcSystem  = 7'b1110011;
  localparam opcodeT opcFenceI  = 7'b0001111;

  localparam funct7T funct7MulDiv = 7'b0000001; // M extension
  localparam funct7T funct7Alt    = 7'b0100000; // sub, subw

  localparam sysFnT sysEcall  = 12'h000;
  localparam sysFnT sysEbreak = 12'h001;
  localparam sysFnT sysMret   = 12'h302;

  typedef enum logic [3:0] {
    clsLui,
    clsAuipc,
    clsJal,
    clsJalr,
    clsBranch,
    clsLoad,
    clsStore,
    clsOpImm,
    clsOp,
    clsOpImm32,
    clsOp32,
    clsSystem,
    clsFenceI,
    clsIllegal
  } instrClassT;

  typedef logic [4:0] aluOpT; // bit 4 set for word ops
  localparam aluOpT aluAdd   = 5'b00000;
  localparam aluOpT aluSll   = 5'b00001;
  localparam aluOpT aluSlt   = 5'b00010;
  localparam aluOpT aluSltu  = 5'b00011;
  localparam aluOpT aluXor   = 5'b00100;
  localparam aluOpT aluSrl   = 5'b00101;
  localparam aluOpT aluOr    = 5'b00110;
  localparam aluOpT aluAnd   = 5'b00111;
  localparam aluOpT aluSub   = 5'b01000;
  localparam aluOpT aluMul   = 5'b01001;
  localparam aluOpT aluDivu  = 5'b01010;
  localparam aluOpT aluDiv   = 5'b01011;
  localparam aluOpT aluRemu  = 5'b01100;
  localparam aluOpT aluSra   = 5'b01101;
  localparam aluOpT aluRem   = 5'b01110;
  localparam aluOpT aluPassB = 5'b01111; // lui, result = imm
  localparam aluOpT aluAddw  = 5'b10000;
  localparam aluOpT aluSllw  = 5'b10001;
  localparam aluOpT aluSrlw  = 5'b10101;
  localparam aluOpT aluSubw  = 5'b11000;
  localparam aluOpT aluMulw  = 5'b11001;
  localparam aluOpT aluDivuw = 5'b11010;
  localparam aluOpT aluDivw  = 5'b11011;
  localparam aluOpT aluRemuw = 5'b11100;
  localparam aluOpT aluSraw  = 5'b11101;
  localparam aluOpT aluRemw  = 5'b11110;

  typedef logic [2:0] immTypeT;
  localparam immTypeT immI = 3'd0;
  localparam immTypeT immU = 3'd1;
  localparam immTypeT immS = 3'd2;
  localparam immTypeT immB = 3'd3;
  localparam immTypeT immJ = 3'd4;
  localparam immTypeT immR = 3'd5; // no immediate

  typedef logic [2:0] memOpT;
  localparam memOpT memWord   = 3'd0;
  localparam memOpT memByte   = 3'd1;
  localparam memOpT memHalf   = 3'd2;
  localparam memOpT memDouble = 3'd3;
  localparam memOpT memWordU  = 3'd4;
  localparam memOpT memByteU  = 3'd5;
  localparam memOpT memHalfU  = 3'd6;

  typedef logic [2:0] branchT;
  localparam branchT brNone = 3'd0;
  localparam branchT brJal  = 3'd1;
  localparam branchT brJalr = 3'd2;
  localparam branchT brEq   = 3'd4;
  localparam branchT brNe   = 3'd5;
  localparam branchT brLt   = 3'd6; // also bltu, alu does sltu
  localparam branchT brGe   = 3'd7; // also bgeu

  typedef logic [1:0] mulOpT;
  localparam mulOpT mulLow = 2'd0;
  localparam mulOpT mulHu  = 2'd1;
  localparam mulOpT mulHsu = 2'd2;
  localparam mulOpT mulH   = 2'd3;

  typedef logic [1:0] csrOpT;
  localparam csrOpT csrWrite = 2'd0;
  localparam csrOpT csrSet   = 2'd1;
  localparam csrOpT csrClear = 2'd2;

  localparam logic       srcAPc   = 1'b0;
  localparam logic       srcARs1  = 1'b1;
  localparam logic [1:0] srcBRs2  = 2'd0;
  localparam logic [1:0] srcBImm  = 2'd1;
  localparam logic [1:0] srcBFour = 2'd2; // link address pc+4

endpackage

// ==== hw/rvDecodeTop.sv ====
`timescale 1ns/1ps

module rvDecodeTop (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic                         valid_i,
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  output logic                         valid_o,
  output logic                         aluSrcA_o,
  output logic [1:0]                   aluSrcB_o,
  output rvDecodePkg::aluOpT           aluOp_o,
  output rvDecodePkg::mulOpT           mulOp_o,
  output rvDecodePkg::immTypeT         immType_o,
  output rvDecodePkg::branchT          branch_o,
  output rvDecodePkg::memOpT           memOp_o,
  output logic                         memWen_o,
  output logic                         memToReg_o,
  output logic                         regWen_o,
  output logic                         csrWen_o,
  output logic                         csrToReg_o,
  output rvDecodePkg::csrOpT           csrOp_o,
  output logic                         csrImm_o,
  output logic                         ecall_o,
  output logic                         ebreak_o,
  output logic                         mret_o,
  output logic                         fenceI_o,
  output logic                         illegal_o
);
  import rvDecodePkg::*;

  instrClassT decCls;
  immTypeT    decImmType;
  logic       decRegWen;
  logic       decIllegal;
  logic       decAluSrcA;
  logic [1:0] decAluSrcB;
  aluOpT      decAluOp;
  mulOpT      decMulOp;
  memOpT      decMemOp;
  logic       decMemWen;
  logic       decMemToReg;
  branchT     decBranch;
  logic       decEcall;
  logic       decEbreak;
  logic       decMret;
  logic       decCsrWen;
  logic       decCsrToReg;
  csrOpT      decCsrOp;
  logic       decCsrImm;
  logic       decFenceI;

  instrClassify uClassify (
    .instr_i   (instr_i),
    .cls_o     (decCls),
    .immType_o (decImmType),
    .regWen_o  (decRegWen),
    .illegal_o (decIllegal)
  );

  aluCtrlDecode uAlu (
    .instr_i   (instr_i),
    .cls_i     (decCls),
    .aluSrcA_o (decAluSrcA),
    .aluSrcB_o (decAluSrcB),
    .aluOp_o   (decAluOp),
    .mulOp_o   (decMulOp)
  );

  memCtrlDecode uMem (
    .instr_i    (instr_i),
    .cls_i      (decCls),
    .memOp_o    (decMemOp),
    .memWen_o   (decMemWen),
    .memToReg_o (decMemToReg)
  );

  branchCtrlDecode uBranch (
    .instr_i  (instr_i),
    .cls_i    (decCls),
    .branch_o (decBranch)
  );

  sysCtrlDecode uSys (
    .instr_i    (instr_i),
    .cls_i      (decCls),
    .ecall_o    (decEcall),
    .ebreak_o   (decEbreak),
    .mret_o     (decMret),
    .csrWen_o   (decCsrWen),
    .csrToReg_o (decCsrToReg),
    .csrOp_o    (decCsrOp),
    .csrImm_o   (decCsrImm),
    .fenceI_o   (decFenceI)
  );

  // decode stage register, a bubble kills every side effect
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o    <= 1'b0;
      regWen_o   <= 1'b0;
      memWen_o   <= 1'b0;
      memToReg_o <= 1'b0;
      csrWen_o   <= 1'b0;
      csrToReg_o <= 1'b0;
      ecall_o    <= 1'b0;
      ebreak_o   <= 1'b0;
      mret_o     <= 1'b0;
      fenceI_o   <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      valid_o    <= valid_i;
      regWen_o   <= valid_i & decRegWen;
      memWen_o   <= valid_i & decMemWen;
      memToReg_o <= valid_i & decMemToReg;
      csrWen_o   <= valid_i & decCsrWen;
      csrToReg_o <= valid_i & decCsrToReg;
      ecall_o    <= valid_i & decEcall;
      ebreak_o   <= valid_i & decEbreak;
      mret_o     <= valid_i & decMret;
      fenceI_o   <= valid_i & decFenceI;
      illegal_o  <= valid_i & decIllegal; // trap only on a real instr
    end
  end

  // operand and format fields, loaded every cycle
  always_ff @(posedge clk) begin
    aluSrcA_o <= decAluSrcA;
    aluSrcB_o <= decAluSrcB;
    aluOp_o   <= decAluOp;
    mulOp_o   <= decMulOp;
    immType_o <= decImmType;
    branch_o  <= decBranch;
    memOp_o   <= decMemOp;
    csrOp_o   <= decCsrOp;
    csrImm_o  <= decCsrImm;
  end

endmodule

// ==== hw/sysCtrlDecode.sv ====
`timescale 1ns/1ps

module sysCtrlDecode (
  input  logic [rvDecodePkg::ilen-1:0] instr_i,
  input  rvDecodePkg::instrClassT      cls_i,
  output logic                         ecall_o,
  output logic                         ebreak_o,
  output logic                         mret_o,
  output logic                         csrWen_o,
  output logic                         csrToReg_o,
  output rvDecodePkg::csrOpT           csrOp_o,
  output logic                         csrImm_o,
  output logic                         fenceI_o
);
  import rvDecodePkg::*;

  funct3T funct3;
  sysFnT  sysFn;
  logic   isTrap; // system, funct3 000
  logic   isCsr;  // csrrw..csrrci
  csrOpT  csrKind;

  assign funct3 = instr_i[funct3Hi:funct3Lo];
  assign sysFn  = instr_i[sysFnHi:sysFnLo];
  assign isTrap = (cls_i == clsSystem) && (funct3 == 3'b000);
  assign isCsr  = (cls_i == clsSystem) && (funct3 != 3'b000);

  // funct3[1:0] picks the op, 00 never reaches here
  always_comb begin
    case (funct3[1:0])
      2'b10:   csrKind = csrSet;
      2'b11:   csrKind = csrClear;
      default: csrKind = csrWrite;
    endcase
  end

  assign ecall_o    = isTrap && (sysFn == sysEcall);
  assign ebreak_o   = isTrap && (sysFn == sysEbreak);
  assign mret_o     = isTrap && (sysFn == sysMret);
  assign csrWen_o   = isCsr;
  assign csrToReg_o = isCsr; // old csr value to rd
  assign csrOp_o    = isCsr ? csrKind : csrWrite;
  assign csrImm_o   = isCsr && funct3[2]; // uimm in rs1 field
  assign fenceI_o   = (cls_i == clsFenceI);

endmodule

// ==== tb/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected control word, one field per DUT output
typedef struct packed {
  logic       valid;
  logic       aluSrcA;
  logic [1:0] aluSrcB;
  aluOpT      aluOp;
  mulOpT      mulOp;
  immTypeT    immType;
  branchT     branch;
  memOpT      memOp;
  logic       memWen;
  logic       memToReg;
  logic       regWen;
  logic       csrWen;
  logic       csrToReg;
  csrOpT      csrOp;
  logic       csrImm;
  logic       ecall;
  logic       ebreak;
  logic       mret;
  logic       fenceI;
  logic       illegal;
} ctrlWordT;

function automatic logic knownOpcode(opcodeT opc);
  return opc inside {opcLui, opcAuipc, opcJal, opcJalr, opcBranch, opcLoad, opcStore,
                     opcOpImm, opcOp, opcOpImm32, opcOp32, opcSystem, opcFenceI};
endfunction

// legality straight from the encoding rules
function automatic logic legalInstr(logic [ilen-1:0] instr);
  funct3T f3;
  sysFnT  fn;
  f3 = instr[14:12];
  fn = instr[31:20];
  case (instr[6:0])
    opcBranch: return !(f3 == 3'b010 || f3 == 3'b011);
    opcLoad:   return f3 != 3'b111;
    opcStore:  return f3 < 3'd4; // sb, sh, sw, sd
    opcSystem: begin
      if (f3 == 3'b000) return fn == 12'h000 || fn == 12'h001 || fn == 12'h302;
      return f3 != 3'b100;
    end
    default:   return knownOpcode(instr[6:0]);
  endcase
endfunction

function automatic memOpT accessKind(funct3T f3);
  case (f3)
    3'b000:  return memByte;
    3'b001:  return memHalf;
    3'b011:  return memDouble;
    3'b100:  return memByteU;
    3'b101:  return memHalfU;
    3'b110:  return memWordU;
    default: return memWord;
  endcase
endfunction

// alu op for op / op-imm and the word forms
function automatic aluOpT arithOp(funct3T f3, funct7T f7, logic isWord, logic isReg);
  aluOpT op;
  if (isReg && f7 == funct7MulDiv) begin
    case (f3)
      3'b100:  op = isWord ? aluDivw : aluDiv;
      3'b101:  op = isWord ? aluDivuw : aluDivu;
      3'b110:  op = isWord ? aluRemw : aluRem;
      3'b111:  op = isWord ? aluRemuw : aluRemu;
      default: op = isWord ? aluMulw : aluMul; // mul, mulh* share one op
    endcase
  end else if (isWord && f3 != 3'b000 && f3 != 3'b001) begin
    op = f7[5] ? aluSraw : aluSrlw; // f7[5] is instr bit 30
  end else begin
    case (f3)
      3'b000:  op = (isReg && f7 == funct7Alt) ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = f7[5] ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    if (isWord) op = op | aluAddw; // bit 4 marks a word op
  end
  return op;
endfunction

function automatic ctrlWordT expectCtrl(logic [ilen-1:0] instr, logic valid, logic rst);
  ctrlWordT c;
  opcodeT   opc;
  funct3T   f3;
  funct7T   f7;
  sysFnT    fn;
  opc       = instr[6:0];
  f3        = instr[14:12];
  f7        = instr[31:25];
  fn        = instr[31:20];
  c         = '0;
  c.aluSrcA = srcARs1; // defaults match the illegal case
  c.aluSrcB = srcBRs2;
  c.aluOp   = aluAdd;
  c.immType = immI;
  c.memOp   = memWord;
  c.csrOp   = csrWrite;
  c.illegal = !legalInstr(instr);
  if (!c.illegal) begin
    case (opc)
      opcLui: begin
        c.immType = immU;
        c.aluSrcB = srcBImm;
        c.aluOp   = aluPassB;
        c.regWen  = 1'b1;
      end
      opcAuipc: begin
        c.immType = immU;
        c.aluSrcA = srcAPc;
        c.aluSrcB = srcBImm;
        c.regWen  = 1'b1;
      end
      opcJal, opcJalr: begin
        c.immType = (opc == opcJal) ? immJ : immI;
        c.branch  = (opc == opcJal) ? brJal : brJalr;
        c.aluSrcA = srcAPc; // link = pc + 4
        c.aluSrcB = srcBFour;
        c.regWen  = 1'b1;
      end
      opcBranch: begin
        c.immType = immB;
        c.aluOp   = (f3 == 3'b110 || f3 == 3'b111) ? aluSltu : aluSlt;
        case (f3)
          3'b000:         c.branch = brEq;
          3'b001:         c.branch = brNe;
          3'b100, 3'b110: c.branch = brLt;
          default:        c.branch = brGe;
        endcase
      end
      opcLoad: begin
        c.aluSrcB  = srcBImm;
        c.memOp    = accessKind(f3);
        c.memToReg = 1'b1;
        c.regWen   = 1'b1;
      end
      opcStore: begin
        c.immType = immS;
        c.aluSrcB = srcBImm;
        c.memOp   = accessKind(f3);
        c.memWen  = 1'b1;
      end
      opcOpImm, opcOpImm32: begin
        c.aluSrcB = srcBImm;
        c.aluOp   = arithOp(f3, f7, opc == opcOpImm32, 1'b0);
        c.regWen  = 1'b1;
      end
      opcOp, opcOp32: begin
        c.immType = immR;
        c.aluOp   = arithOp(f3, f7, opc == opcOp32, 1'b1);
        c.regWen  = 1'b1;
        if (opc == opcOp && f7 == funct7MulDiv) begin
          case (f3)
            3'b001:  c.mulOp = mulH;
            3'b010:  c.mulOp = mulHsu;
            3'b011:  c.mulOp = mulHu;
            default: c.mulOp = mulLow;
          endcase
        end
      end
      opcSystem: begin
        c.aluSrcB = srcBImm;
        if (f3 == 3'b000) begin
          c.ecall  = (fn == sysEcall);
          c.ebreak = (fn == sysEbreak);
          c.mret   = (fn == sysMret);
        end else begin
          c.regWen   = 1'b1; // old csr value to rd
          c.csrWen   = 1'b1;
          c.csrToReg = 1'b1;
          c.csrImm   = f3[2];
          if (f3[1:0] == 2'b10) c.csrOp = csrSet;
          else if (f3[1:0] == 2'b11) c.csrOp = csrClear;
        end
      end
      default: c.fenceI = 1'b1; // only fence.i is left
    endcase
  end
  // bubble or reset kills every side effect
  if (rst || !valid) begin
    c.regWen   = 1'b0;
    c.memWen   = 1'b0;
    c.memToReg = 1'b0;
    c.csrWen   = 1'b0;
    c.csrToReg = 1'b0;
    c.ecall    = 1'b0;
    c.ebreak   = 1'b0;
    c.mret     = 1'b0;
    c.fenceI   = 1'b0;
    c.illegal  = 1'b0;
  end
  c.valid = valid && !rst;
  return c;
endfunction

`endif

// ==== tb/rvDecodeTb.sv ====
`timescale 1ns/1ps

module rvDecodeTb;
  import rvDecodePkg::*;

  `include "decodeModel.svh"

  logic            clk = 1'b0;
  logic            rst_i;
  logic            valid_i;
  logic [ilen-1:0] instr_i;
  logic            valid_o;
  logic            aluSrcA_o;
  logic [1:0]      aluSrcB_o;
  aluOpT           aluOp_o;
  mulOpT           mulOp_o;
  immTypeT         immType_o;
  branchT          branch_o;
  memOpT           memOp_o;
  logic            memWen_o;
  logic            memToReg_o;
  logic            regWen_o;
  logic            csrWen_o;
  logic            csrToReg_o;
  csrOpT           csrOp_o;
  logic            csrImm_o;
  logic            ecall_o;
  logic            ebreak_o;
  logic            mret_o;
  logic            fenceI_o;
  logic            illegal_o;

  ctrlWordT expQ[$]; // one entry per rising edge
  logic     sampling;
  int       errCount;
  int       timeoutCount;
  int       checkCount;

  rvDecodeTop dut (.*); // tb signals carry the port names

  initial begin
    forever #50 clk = ~clk; // 100 ns period
  end

  // model result for what the dut samples at this edge
  always @(posedge clk) begin
    if (sampling) expQ.push_back(expectCtrl(instr_i, valid_i, rst_i));
  end

  task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("MISMATCH at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic scoreOutputs(input ctrlWordT e);
    checkCount++;
    checkValue("valid_o", 8'(valid_o), 8'(e.valid));
    checkValue("aluSrcA_o", 8'(aluSrcA_o), 8'(e.aluSrcA));
    checkValue("aluSrcB_o", 8'(aluSrcB_o), 8'(e.aluSrcB));
    checkValue("aluOp_o", 8'(aluOp_o), 8'(e.aluOp));
    checkValue("mulOp_o", 8'(mulOp_o), 8'(e.mulOp));
    checkValue("immType_o", 8'(immType_o), 8'(e.immType));
    checkValue("branch_o", 8'(branch_o), 8'(e.branch));
    checkValue("memOp_o", 8'(memOp_o), 8'(e.memOp));
    checkValue("memWen_o", 8'(memWen_o), 8'(e.memWen));
    checkValue("memToReg_o", 8'(memToReg_o), 8'(e.memToReg));
    checkValue("regWen_o", 8'(regWen_o), 8'(e.regWen));
    checkValue("csrWen_o", 8'(csrWen_o), 8'(e.csrWen));
    checkValue("csrToReg_o", 8'(csrToReg_o), 8'(e.csrToReg));
    checkValue("csrOp_o", 8'(csrOp_o), 8'(e.csrOp));
    checkValue("csrImm_o", 8'(csrImm_o), 8'(e.csrImm));
    checkValue("ecall_o", 8'(ecall_o), 8'(e.ecall));
    checkValue("ebreak_o", 8'(ebreak_o), 8'(e.ebreak));
    checkValue("mret_o", 8'(mret_o), 8'(e.mret));
    checkValue("fenceI_o", 8'(fenceI_o), 8'(e.fenceI));
    checkValue("illegal_o", 8'(illegal_o), 8'(e.illegal));
  endtask

  task automatic popAndScore();
    ctrlWordT e;
    if (expQ.size() != 0) begin
      e = expQ.pop_front();
      scoreOutputs(e);
    end
  endtask

  // score last cycle then drive the next input on the falling edge
  task automatic stepCycle(input logic v, input logic [ilen-1:0] w);
    @(negedge clk);
    popAndScore();
    valid_i = v;
    instr_i = w;
  endtask

  task automatic waitForValidOut(input int limit, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < limit && !ok; n++) begin
      stepCycle(1'b0, instr_i);
      ok = valid_o;
    end
  endtask

  task automatic drainQueue(input int limit, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < limit && !ok; n++) begin
      @(negedge clk);
      popAndScore();
      sampling = 1'b0; // nothing new after the last drive
      ok = (expQ.size() == 0);
    end
  endtask

  // random legal instruction of any class
  function automatic logic [ilen-1:0] legalWord();
    logic [ilen-1:0] w;
    funct3T          f3;
    int              sel;
    w   = $urandom();
    f3  = w[14:12];
    sel = $urandom_range(2, 0); // funct7 / trap flavour
    case ($urandom_range(12, 0))
      0: w[6:0] = opcLui;
      1: w[6:0] = opcAuipc;
      2: w[6:0] = opcJal;
      3: begin
        w[6:0] = opcJalr;
        f3     = 3'b000;
      end
      4: begin
        w[6:0] = opcBranch;
        if (f3[2:1] == 2'b01) f3[1] = 1'b0; // reserved -> beq/bne
      end
      5: begin
        w[6:0] = opcLoad;
        if (f3 == 3'b111) f3 = 3'($urandom_range(6, 0));
      end
      6: begin
        w[6:0] = opcStore;
        f3[2]  = 1'b0;
      end
      7: begin
        w[6:0] = opcOpImm;
        if (f3 == 3'b001) w[31:26] = 6'b000000;
        if (f3 == 3'b101) w[31:26] = (sel == 1) ? 6'b010000 : 6'b000000; // srai / srli
      end
      8: begin
        w[6:0]   = opcOp;
        w[31:25] = (sel == 0) ? 7'b0 : ((sel == 1) ? funct7Alt : funct7MulDiv);
        if (sel == 1 && f3 != 3'b101) f3 = 3'b000; // sub or sra
      end
      9: begin
        w[6:0] = opcOpImm32;
        if (f3 != 3'b000 && f3 != 3'b001) f3 = 3'b101;
        if (f3 != 3'b000) w[31:25] = (f3 == 3'b101 && sel == 1) ? funct7Alt : 7'b0;
      end
      10: begin
        w[6:0]   = opcOp32;
        w[31:25] = (sel == 0) ? 7'b0 : ((sel == 1) ? funct7Alt : funct7MulDiv);
        if (sel == 2 && f3 inside {3'b001, 3'b010, 3'b011}) f3 = 3'b000;
        if (sel != 2 && !(f3 inside {3'b000, 3'b001, 3'b101})) f3 = 3'b000;
        if (sel == 1 && f3 == 3'b001) f3 = 3'b000; // subw
      end
      11: begin
        w[6:0] = opcSystem;
        if (f3 == 3'b100) f3 = 3'b000;
        if (f3 == 3'b000) begin
          case (sel)
            0:       w[31:20] = sysEcall;
            1:       w[31:20] = sysEbreak;
            default: w[31:20] = sysMret;
          endcase
        end
      end
      default: begin
        w[6:0] = opcFenceI;
        f3     = 3'b001;
      end
    endcase
    w[14:12] = f3;
    return w;
  endfunction

  function automatic logic [ilen-1:0] illegalWord();
    logic [ilen-1:0] w;
    w = $urandom();
    case ($urandom_range(5, 0))
      0: begin
        for (int n = 0; n < 64 && knownOpcode(w[6:0]); n++) w[6:0] = 7'($urandom());
        if (knownOpcode(w[6:0])) w[6:0] = 7'b1111111;
      end
      1: begin
        w[6:0]   = opcBranch;
        w[14:13] = 2'b01; // funct3 010 / 011
      end
      2: begin
        w[6:0]   = opcLoad;
        w[14:12] = 3'b111;
      end
      3: begin
        w[6:0] = opcStore;
        w[14]  = 1'b1;
      end
      4: begin
        w[6:0]   = opcSystem;
        w[14:12] = 3'b100;
      end
      default: begin
        w[6:0]   = opcSystem;
        w[14:12] = 3'b000;
        if (w[31:20] inside {sysEcall, sysEbreak, sysMret}) w[31:20] = 12'hfff;
      end
    endcase
    return w;
  endfunction

  function automatic logic [ilen-1:0] mixedWord();
    case ($urandom_range(2, 0))
      0:       return legalWord();
      1:       return illegalWord();
      default: return $urandom(); // raw word
    endcase
  endfunction

  initial begin
    bit ok;
    void'($urandom(53307));
    rst_i        = 1'b1;
    valid_i      = 1'b0;
    instr_i      = '0;
    sampling     = 1'b1;
    errCount     = 0;
    timeoutCount = 0;
    checkCount   = 0;

    // junk on the inputs while reset is held
    repeat (15) stepCycle(1'($urandom_range(1, 0)), mixedWord());
    stepCycle(1'b0, mixedWord()); // first edge out of reset is a bubble
    rst_i = 1'b0;

    stepCycle(1'b1, legalWord());
    waitForValidOut(8, ok);
    if (!ok) begin
      timeoutCount++;
      $display("timeout: valid_o never rose after the first valid instruction");
    end else begin
      repeat (3000) stepCycle(1'b1, legalWord());
      repeat (1000) stepCycle(1'b1, illegalWord());
      // ~25% bubbles
      repeat (2000) begin
        stepCycle($urandom_range(3, 0) != 0,
                  ($urandom_range(3, 0) == 0) ? illegalWord() : legalWord());
      end
      repeat (4000) stepCycle(1'b1, mixedWord()); // back-to-back
      stepCycle(1'b0, mixedWord());
      drainQueue(8, ok);
      if (!ok) begin
        timeoutCount++;
        $display("timeout: expected results still pending after the last instruction");
      end
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
